/* rv_backend_pkg.sv */
/*
  RISC-V back end shared definitions
  Widths, data RAM geometry and the memory/write-back encodings
*/
`default_nettype none

package rv_backend_pkg;

  // Datapath and register file geometry
  localparam int XLEN_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int REG_COUNT  = 32;  // Integer registers x0..x31

  // Data RAM, byte address bits 9:0 used
  localparam int DMEM_WORDS  = 256;
  localparam int DMEM_ADDR_W = 8;  // Word index taken from address bits 9:2

  // Memory operation carried from execute
  typedef enum logic [3:0] {
    MEM_NONE = 4'd0,
    MEM_LB   = 4'd1,
    MEM_LH   = 4'd2,
    MEM_LW   = 4'd3,
    MEM_LBU  = 4'd4,
    MEM_LHU  = 4'd5,
    MEM_SB   = 4'd6,
    MEM_SH   = 4'd7,
    MEM_SW   = 4'd8
  } mem_op_e;

  // Write-back source
  typedef enum logic [1:0] {
    WB_ALU = 2'd0,  // ALU result
    WB_MEM = 2'd1,  // Extended load data
    WB_PC4 = 2'd2   // Link address for JAL/JALR
  } wb_sel_e;

endpackage

`default_nettype wire

/* mem_stage.sv */
/*
  Memory stage
  Private data RAM with byte-lane stores and synchronous reads,
  load data is lane-selected and sign/zero extended after the edge
*/
`timescale 1ns/1ns
`default_nettype none

module mem_stage import rv_backend_pkg::*; (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              ex_valid,
  input  logic [XLEN_W-1:0] ex_alu_result,   // Effective address for loads/stores
  input  logic [XLEN_W-1:0] ex_store_data,
  input  logic [REG_ADDR_W-1:0] ex_rd_addr,
  input  logic              ex_reg_write,
  input  wb_sel_e           ex_wb_sel,
  input  mem_op_e           ex_mem_op,
  input  logic [XLEN_W-1:0] ex_pc_plus_4,
  output logic              mem_valid,
  output logic [XLEN_W-1:0] mem_alu_result,
  output logic [XLEN_W-1:0] mem_load_data,
  output logic [REG_ADDR_W-1:0] mem_rd_addr,
  output logic              mem_reg_write,
  output wb_sel_e           mem_wb_sel,
  output logic [XLEN_W-1:0] mem_pc_plus_4
);

  logic [XLEN_W-1:0]      dmem [DMEM_WORDS];
  logic [DMEM_ADDR_W-1:0] word_idx;
  logic [3:0]             st_be;
  logic [XLEN_W-1:0]      st_data;
  logic [XLEN_W-1:0]      rd_word;   // Word read at the issue edge
  logic [1:0]             off_q;     // Byte offset of the load
  mem_op_e                op_q;
  logic [7:0]             ld_byte;
  logic [15:0]            ld_half;

  assign word_idx = ex_alu_result[DMEM_ADDR_W+1:2];

  // Lane enables and replicated store data
  always_comb begin
    st_be   = 4'b0000;
    st_data = ex_store_data;
    case (ex_mem_op)
      MEM_SB: begin
        st_be   = 4'b0001 << ex_alu_result[1:0];
        st_data = {4{ex_store_data[7:0]}};
      end
      MEM_SH: begin
        st_be   = ex_alu_result[1] ? 4'b1100 : 4'b0011;
        st_data = {2{ex_store_data[15:0]}};
      end
      MEM_SW:  st_be = 4'b1111;
      default: st_be = 4'b0000;
    endcase
  end

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      for (int i = 0; i < 4; i++) begin
        if (st_be[i]) dmem[word_idx][i*8 +: 8] <= st_data[i*8 +: 8];
      end
    end
    rd_word <= dmem[word_idx];  // Old data, a store and a load never share an edge
  end

  // Control and payload fields
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mem_valid      <= 1'b0;
      mem_alu_result <= '0;
      mem_rd_addr    <= '0;
      mem_reg_write  <= 1'b0;
      mem_wb_sel     <= WB_ALU;
      mem_pc_plus_4  <= '0;
      off_q          <= 2'b00;
      op_q           <= MEM_NONE;
    end else begin
      mem_valid      <= ex_valid;
      mem_alu_result <= ex_alu_result;
      mem_rd_addr    <= ex_rd_addr;
      mem_reg_write  <= ex_reg_write;
      mem_wb_sel     <= ex_wb_sel;
      mem_pc_plus_4  <= ex_pc_plus_4;
      off_q          <= ex_alu_result[1:0];
      op_q           <= ex_mem_op;
    end
  end

  assign ld_byte = rd_word[{off_q, 3'b000} +: 8];
  assign ld_half = off_q[1] ? rd_word[31:16] : rd_word[15:0];

  // Load extension, zero for anything that is not a load
  always_comb begin
    case (op_q)
      MEM_LB:  mem_load_data = {{24{ld_byte[7]}}, ld_byte};
      MEM_LBU: mem_load_data = {24'h0, ld_byte};
      MEM_LH:  mem_load_data = {{16{ld_half[15]}}, ld_half};
      MEM_LHU: mem_load_data = {16'h0, ld_half};
      MEM_LW:  mem_load_data = rd_word;
      default: mem_load_data = '0;
    endcase
  end

endmodule

`default_nettype wire

/* memwb_register.sv */
/*
  MEM/WB pipeline register
  Latches every memory-stage field for write-back, no stall or flush
*/
`timescale 1ns/1ns
`default_nettype none

module memwb_register import rv_backend_pkg::*; (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              mem_valid,
  input  logic [XLEN_W-1:0] mem_alu_result,
  input  logic [XLEN_W-1:0] mem_load_data,
  input  logic [REG_ADDR_W-1:0] mem_rd_addr,
  input  logic              mem_reg_write,
  input  wb_sel_e           mem_wb_sel,
  input  logic [XLEN_W-1:0] mem_pc_plus_4,
  output logic              wbs_valid,
  output logic [XLEN_W-1:0] wbs_alu_result,
  output logic [XLEN_W-1:0] wbs_load_data,
  output logic [REG_ADDR_W-1:0] wbs_rd_addr,
  output logic              wbs_reg_write,
  output wb_sel_e           wbs_wb_sel,
  output logic [XLEN_W-1:0] wbs_pc_plus_4
);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      // Empty bubble in write-back
      wbs_valid      <= 1'b0;
      wbs_alu_result <= '0;
      wbs_load_data  <= '0;
      wbs_rd_addr    <= '0;
      wbs_reg_write  <= 1'b0;
      wbs_wb_sel     <= WB_ALU;
      wbs_pc_plus_4  <= '0;
    end else begin
      wbs_valid      <= mem_valid;
      wbs_alu_result <= mem_alu_result;
      wbs_load_data  <= mem_load_data;   // Already extended
      wbs_rd_addr    <= mem_rd_addr;
      wbs_reg_write  <= mem_reg_write;
      wbs_wb_sel     <= mem_wb_sel;
      wbs_pc_plus_4  <= mem_pc_plus_4;
    end
  end

endmodule

`default_nettype wire

/* writeback_regfile.sv */
/*
  Write-back stage and integer register file
  Selects the result source, writes x1..x31 and serves a debug read port
*/
`timescale 1ns/1ns
`default_nettype none

module writeback_regfile import rv_backend_pkg::*; (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              wbs_valid,
  input  logic [XLEN_W-1:0] wbs_alu_result,
  input  logic [XLEN_W-1:0] wbs_load_data,
  input  logic [REG_ADDR_W-1:0] wbs_rd_addr,
  input  logic              wbs_reg_write,
  input  wb_sel_e           wbs_wb_sel,
  input  logic [XLEN_W-1:0] wbs_pc_plus_4,
  input  logic [REG_ADDR_W-1:0] dbg_rs_addr,
  output logic              wb_valid,
  output logic [REG_ADDR_W-1:0] wb_rd_addr,
  output logic              wb_reg_write,
  output logic [XLEN_W-1:0] wb_data,
  output logic [XLEN_W-1:0] dbg_rs_data
);

  logic [XLEN_W-1:0] regs [REG_COUNT];
  logic              rf_we;

  // Result source select
  always_comb begin
    case (wbs_wb_sel)
      WB_ALU:  wb_data = wbs_alu_result;
      WB_MEM:  wb_data = wbs_load_data;
      WB_PC4:  wb_data = wbs_pc_plus_4;
      default: wb_data = '0;
    endcase
  end

  // Request as applied to the register file
  assign wb_valid     = wbs_valid;
  assign wb_rd_addr   = wbs_rd_addr;
  assign wb_reg_write = wbs_reg_write;

  // x0 is hardwired, its writes are dropped
  assign rf_we = wbs_valid && wbs_reg_write && (wbs_rd_addr != '0);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_we) begin
      regs[wbs_rd_addr] <= wb_data;
    end
  end

  // Debug read, no bypass of the write in flight
  assign dbg_rs_data = (dbg_rs_addr == '0) ? '0 : regs[dbg_rs_addr];

endmodule

`default_nettype wire

/* rv_backend_top.sv */
/*
  RISC-V integer back end
  Memory stage, MEM/WB register and write-back with register file
*/
`timescale 1ns/1ns
`default_nettype none

module rv_backend_top import rv_backend_pkg::*; (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              ex_valid,
  input  logic [XLEN_W-1:0] ex_alu_result,
  input  logic [XLEN_W-1:0] ex_store_data,
  input  logic [REG_ADDR_W-1:0] ex_rd_addr,
  input  logic              ex_reg_write,
  input  wb_sel_e           ex_wb_sel,
  input  mem_op_e           ex_mem_op,
  input  logic [XLEN_W-1:0] ex_pc_plus_4,
  input  logic [REG_ADDR_W-1:0] dbg_rs_addr,
  output logic              wb_valid,
  output logic [REG_ADDR_W-1:0] wb_rd_addr,
  output logic              wb_reg_write,
  output logic [XLEN_W-1:0] wb_data,
  output logic [XLEN_W-1:0] dbg_rs_data
);

  // Memory stage outputs
  logic              mem_valid;
  logic [XLEN_W-1:0] mem_alu_result;
  logic [XLEN_W-1:0] mem_load_data;
  logic [REG_ADDR_W-1:0] mem_rd_addr;
  logic              mem_reg_write;
  wb_sel_e           mem_wb_sel;
  logic [XLEN_W-1:0] mem_pc_plus_4;

  // MEM/WB register outputs
  logic              wbs_valid;
  logic [XLEN_W-1:0] wbs_alu_result;
  logic [XLEN_W-1:0] wbs_load_data;
  logic [REG_ADDR_W-1:0] wbs_rd_addr;
  logic              wbs_reg_write;
  wb_sel_e           wbs_wb_sel;
  logic [XLEN_W-1:0] wbs_pc_plus_4;

  mem_stage u_mem_stage (
    .clk            (clk),
    .reset_n        (reset_n),
    .ex_valid       (ex_valid),
    .ex_alu_result  (ex_alu_result),
    .ex_store_data  (ex_store_data),
    .ex_rd_addr     (ex_rd_addr),
    .ex_reg_write   (ex_reg_write),
    .ex_wb_sel      (ex_wb_sel),
    .ex_mem_op      (ex_mem_op),
    .ex_pc_plus_4   (ex_pc_plus_4),
    .mem_valid      (mem_valid),
    .mem_alu_result (mem_alu_result),
    .mem_load_data  (mem_load_data),
    .mem_rd_addr    (mem_rd_addr),
    .mem_reg_write  (mem_reg_write),
    .mem_wb_sel     (mem_wb_sel),
    .mem_pc_plus_4  (mem_pc_plus_4)
  );

  memwb_register u_memwb_register (
    .clk            (clk),
    .reset_n        (reset_n),
    .mem_valid      (mem_valid),
    .mem_alu_result (mem_alu_result),
    .mem_load_data  (mem_load_data),
    .mem_rd_addr    (mem_rd_addr),
    .mem_reg_write  (mem_reg_write),
    .mem_wb_sel     (mem_wb_sel),
    .mem_pc_plus_4  (mem_pc_plus_4),
    .wbs_valid      (wbs_valid),
    .wbs_alu_result (wbs_alu_result),
    .wbs_load_data  (wbs_load_data),
    .wbs_rd_addr    (wbs_rd_addr),
    .wbs_reg_write  (wbs_reg_write),
    .wbs_wb_sel     (wbs_wb_sel),
    .wbs_pc_plus_4  (wbs_pc_plus_4)
  );

  writeback_regfile u_writeback_regfile (
    .clk            (clk),
    .reset_n        (reset_n),
    .wbs_valid      (wbs_valid),
    .wbs_alu_result (wbs_alu_result),
    .wbs_load_data  (wbs_load_data),
    .wbs_rd_addr    (wbs_rd_addr),
    .wbs_reg_write  (wbs_reg_write),
    .wbs_wb_sel     (wbs_wb_sel),
    .wbs_pc_plus_4  (wbs_pc_plus_4),
    .dbg_rs_addr    (dbg_rs_addr),
    .wb_valid       (wb_valid),
    .wb_rd_addr     (wb_rd_addr),
    .wb_reg_write   (wb_reg_write),
    .wb_data        (wb_data),
    .dbg_rs_data    (dbg_rs_data)
  );

endmodule

`default_nettype wire

/* tb_rv_backend.sv */
/*
  Testbench for the RISC-V integer back end
  Acts as the execute stage and checks write-back requests and the
  register file against a reference memory and register file
*/
`timescale 1ns/1ns
`default_nettype none

module tb_rv_backend import rv_backend_pkg::*; ();

  localparam int RESET_CYCLES   = 10;
  localparam int INIT_WORDS     = 16;   // Words reached by random addresses
  localparam int RANDOM_COUNT   = 300;
  localparam int TEST_CYCLES    = RESET_CYCLES + INIT_WORDS + 2*REG_COUNT + 48 + RANDOM_COUNT;
  localparam int TIMEOUT_CYCLES = 2*TEST_CYCLES + 100;

  logic                  clk = 1'b0;
  logic                  reset_n;
  logic                  ex_valid;
  logic [XLEN_W-1:0]     ex_alu_result;
  logic [XLEN_W-1:0]     ex_store_data;
  logic [REG_ADDR_W-1:0] ex_rd_addr;
  logic                  ex_reg_write;
  wb_sel_e               ex_wb_sel;
  mem_op_e               ex_mem_op;
  logic [XLEN_W-1:0]     ex_pc_plus_4;
  logic [REG_ADDR_W-1:0] dbg_rs_addr;
  logic                  wb_valid;
  logic [REG_ADDR_W-1:0] wb_rd_addr;
  logic                  wb_reg_write;
  logic [XLEN_W-1:0]     wb_data;
  logic [XLEN_W-1:0]     dbg_rs_data;

  // Reference state and the two in-flight slots ahead of the register file
  logic [XLEN_W-1:0]     ref_mem [DMEM_WORDS];
  logic [XLEN_W-1:0]     ref_rf [REG_COUNT];
  logic                  p1_valid, p1_we, p2_valid, p2_we;
  logic [REG_ADDR_W-1:0] p1_rd, p2_rd;
  logic [XLEN_W-1:0]     p1_data, p2_data, pc_next;
  int                    cycle_count = 0;

  always #4 clk = ~clk;

  rv_backend_top UUT (.*);

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic value_mismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("[FAIL] time %0t: %s expected 0x%08h, got 0x%08h", $time, name, expected, actual);
    abort_run("Value mismatch");
  endtask

  // Byte or half picked by the offset and extended as the load asks
  function automatic logic [XLEN_W-1:0] load_value(input mem_op_e op,
                                                   input logic [XLEN_W-1:0] word,
                                                   input logic [1:0] off);
    logic [XLEN_W-1:0] byte_sh;
    logic [XLEN_W-1:0] half_sh;
    byte_sh = word >> (8 * off);
    half_sh = word >> (16 * off[1]);
    case (op)
      MEM_LB:  return {{24{byte_sh[7]}}, byte_sh[7:0]};
      MEM_LBU: return {24'h0, byte_sh[7:0]};
      MEM_LH:  return {{16{half_sh[15]}}, half_sh[15:0]};
      MEM_LHU: return {16'h0, half_sh[15:0]};
      MEM_LW:  return word;
      default: return '0;
    endcase
  endfunction

  // Reference pipeline sampling the same inputs as the DUT
  always @(posedge clk) begin : model
    logic [DMEM_ADDR_W-1:0] idx;
    logic [1:0]             off;
    logic [XLEN_W-1:0]      ld;
    idx = ex_alu_result[DMEM_ADDR_W+1:2];
    off = ex_alu_result[1:0];
    if (!reset_n) begin
      p1_valid = 1'b0;
      p2_valid = 1'b0;
      for (int i = 0; i < REG_COUNT; i++) ref_rf[i] = '0;
    end else begin
      if (p2_valid && p2_we && p2_rd != '0) ref_rf[p2_rd] = p2_data;
      p2_valid = p1_valid;
      p2_we    = p1_we;
      p2_rd    = p1_rd;
      p2_data  = p1_data;
      ld = load_value(ex_mem_op, ref_mem[idx], off);
      if (ex_valid) begin
        case (ex_mem_op)
          MEM_SB:  ref_mem[idx][8*off +: 8] = ex_store_data[7:0];
          MEM_SH:  ref_mem[idx][16*off[1] +: 16] = ex_store_data[15:0];
          MEM_SW:  ref_mem[idx] = ex_store_data;
          default: ;
        endcase
      end
      p1_valid = ex_valid;
      p1_we    = ex_reg_write;
      p1_rd    = ex_rd_addr;
      case (ex_wb_sel)
        WB_MEM:  p1_data = ld;
        WB_PC4:  p1_data = ex_pc_plus_4;
        default: p1_data = ex_alu_result;
      endcase
    end
  end

  // Write-back stays idle while reset is held
  assert property (@(posedge clk) !reset_n |-> !wb_valid)
    else value_mismatch("wb_valid", 32'd0, 32'(wb_valid));
  assert property (@(posedge clk) !reset_n |-> !wb_reg_write)
    else value_mismatch("wb_reg_write", 32'd0, 32'(wb_reg_write));

  always @(negedge clk) begin
    assert (wb_valid === p2_valid) else value_mismatch("wb_valid", 32'(p2_valid), 32'(wb_valid));
    if (p2_valid) begin
      assert (wb_rd_addr === p2_rd)
        else value_mismatch("wb_rd_addr", 32'(p2_rd), 32'(wb_rd_addr));
      assert (wb_reg_write === p2_we)
        else value_mismatch("wb_reg_write", 32'(p2_we), 32'(wb_reg_write));
      assert (wb_data === p2_data) else value_mismatch("wb_data", p2_data, wb_data);
    end
    assert (dbg_rs_data === ref_rf[dbg_rs_addr])
      else value_mismatch("dbg_rs_data", ref_rf[dbg_rs_addr], dbg_rs_data);
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) abort_run("Timeout, the test sequence did not finish");
  end

  task automatic issue(input mem_op_e op, input logic [31:0] alu, input logic [31:0] sdata,
                       input logic [4:0] rd, input logic we, input wb_sel_e sel);
    @(posedge clk);
    ex_valid      <= 1'b1;
    ex_mem_op     <= op;
    ex_alu_result <= alu;
    ex_store_data <= sdata;
    ex_rd_addr    <= rd;
    ex_reg_write  <= we;
    ex_wb_sel     <= sel;
    ex_pc_plus_4  <= pc_next + 32'd4;
    pc_next = pc_next + 32'd4;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      ex_valid     <= 1'b0;
      ex_reg_write <= 1'b0;
      ex_mem_op    <= MEM_NONE;
    end
  endtask

  task automatic sweep_registers();
    for (int i = 0; i < REG_COUNT; i++) begin
      idle(1);
      dbg_rs_addr <= i[REG_ADDR_W-1:0];
    end
  endtask

  initial begin : stimulus
    logic [31:0] addr;
    logic [31:0] rnd_op;
    logic [31:0] rnd_sel;
    logic [31:0] rnd_ctl;
    mem_op_e     op;
    void'($urandom(32'h0917cbbc));
    pc_next = 32'h0000_1000;
    reset_n       <= 1'b0;
    ex_valid      <= 1'b0;
    ex_alu_result <= '0;
    ex_store_data <= '0;
    ex_rd_addr    <= '0;
    ex_reg_write  <= 1'b0;
    ex_wb_sel     <= WB_ALU;
    ex_mem_op     <= MEM_NONE;
    ex_pc_plus_4  <= '0;
    dbg_rs_addr   <= '0;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      dbg_rs_addr <= i[REG_ADDR_W-1:0];
    end
    reset_n <= 1'b1;
    sweep_registers();  // Whole register file reads zero after reset

    // Fill the random address window
    for (int w = 0; w < INIT_WORDS; w++) begin
      addr = w * 4;
      issue(MEM_SW, addr, (addr * 32'h9E37_79B9) ^ 32'h5A3C_C3A5, 5'd0, 1'b0, WB_ALU);
    end

    issue(MEM_NONE, 32'h1234_5678, 32'h0, 5'd5, 1'b1, WB_ALU);
    dbg_rs_addr <= 5'd5;
    idle(3);

    // Store then load on the next cycle
    issue(MEM_SW, 32'h80, 32'hDEAD_BEEF, 5'd0, 1'b0, WB_ALU);
    issue(MEM_LW, 32'h80, 32'h0, 5'd6, 1'b1, WB_MEM);
    dbg_rs_addr <= 5'd6;

    // Lanes of word 0x84 end up as 0x80017EA5
    issue(MEM_SW, 32'h84, 32'h0, 5'd0, 1'b0, WB_ALU);
    issue(MEM_SB, 32'h84, 32'hFFFF_FFA5, 5'd0, 1'b0, WB_ALU);
    issue(MEM_SB, 32'h85, 32'h0000_007E, 5'd0, 1'b0, WB_ALU);
    issue(MEM_SH, 32'h86, 32'h5555_8001, 5'd0, 1'b0, WB_ALU);
    issue(MEM_LB, 32'h84, 32'h0, 5'd10, 1'b1, WB_MEM);
    issue(MEM_LBU, 32'h84, 32'h0, 5'd11, 1'b1, WB_MEM);
    issue(MEM_LB, 32'h85, 32'h0, 5'd12, 1'b1, WB_MEM);
    issue(MEM_LBU, 32'h87, 32'h0, 5'd13, 1'b1, WB_MEM);
    issue(MEM_LH, 32'h86, 32'h0, 5'd14, 1'b1, WB_MEM);
    issue(MEM_LHU, 32'h86, 32'h0, 5'd15, 1'b1, WB_MEM);
    issue(MEM_LH, 32'h84, 32'h0, 5'd16, 1'b1, WB_MEM);
    issue(MEM_LW, 32'h84, 32'h0, 5'd17, 1'b1, WB_MEM);

    // Link address, x0 and disabled writes
    issue(MEM_NONE, 32'h0, 32'h0, 5'd7, 1'b1, WB_PC4);
    issue(MEM_NONE, 32'hFFFF_FFFF, 32'h0, 5'd0, 1'b1, WB_ALU);
    dbg_rs_addr <= 5'd0;
    issue(MEM_NONE, 32'hCAFE_F00D, 32'h0, 5'd5, 1'b0, WB_ALU);
    issue(MEM_LW, 32'h80, 32'h0, 5'd6, 1'b0, WB_MEM);
    dbg_rs_addr <= 5'd5;
    idle(3);

    for (int n = 0; n < RANDOM_COUNT; n++) begin
      rnd_op  = $urandom_range(8, 0);
      rnd_sel = $urandom_range(2, 0);
      rnd_ctl = $urandom();
      addr    = $urandom() & 32'hFC00_003F;  // Upper bits are ignored by the RAM
      op      = mem_op_e'(rnd_op[3:0]);
      if (op inside {MEM_LW, MEM_SW}) addr[1:0] = 2'b00;
      if (op inside {MEM_LH, MEM_LHU, MEM_SH}) addr[0] = 1'b0;
      issue(op, addr, $urandom(), rnd_ctl[4:0], |rnd_ctl[6:5], wb_sel_e'(rnd_sel[1:0]));
      dbg_rs_addr <= rnd_ctl[13:9];
    end
    idle(3);
    sweep_registers();
    idle(1);

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

/* rv_backend_top.f */
rv_backend_pkg.sv
mem_stage.sv
memwb_register.sv
writeback_regfile.sv
rv_backend_top.sv
tb_rv_backend.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the back-end testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_rv_backend \
    -f rv_backend_top.f -Mdir obj_dir -o tb_rv_backend > build.log 2>&1; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/tb_rv_backend > sim.log 2>&1
run_status=$?

if grep -q "Regression failed" sim.log; then
  echo "Simulation FAILED, see sim.log"
  exit 1
fi
if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status, see sim.log"
  exit 1
fi
echo "Simulation completed without failures"
exit 0
